/* common/cornet_defines.svh */
// Cornet CPU parameters

`ifndef CORNET_DEFINES_SVH
`define CORNET_DEFINES_SVH

// width of the memory port.
`define CORNET_ADDR_W 16
`define CORNET_DATA_W 8

// the vector is read low byte first, starting at this address.
`define CORNET_RESET_VECTOR 16'hFFFC

// An instruction is at most three bytes long.
`define CORNET_PC_STEP_W 2

`endif

/* common/cornet_pkg.sv */
// Cornet CPU shared types

`include "cornet_defines.svh"

package cornet_pkg;

   typedef logic [`CORNET_ADDR_W-1:0] addr_t;
   typedef logic [`CORNET_DATA_W-1:0] data_t;

   // BE is taken as LDA abs,Y here rather than the usual LDX abs,Y.
   typedef enum logic [7:0] {
      OP_LDY_IMM   = 8'hA0,
      OP_LDX_IMM   = 8'hA2,
      OP_LDA_IMM   = 8'hA9,
      OP_LDA_ZP    = 8'hA5,
      OP_LDA_ABS   = 8'hAD,
      OP_LDA_ABS_X = 8'hBD,
      OP_LDA_ABS_Y = 8'hBE,
      OP_STA_ZP    = 8'h85,
      OP_STA_ABS   = 8'h8D,
      OP_STA_ABS_X = 8'h9D,
      OP_INX       = 8'hE8,
      OP_INY       = 8'hC8,
      OP_CMP_IMM   = 8'hC9,
      OP_CPX_IMM   = 8'hE0,
      OP_CPY_IMM   = 8'hC0,
      OP_BNE       = 8'hD0,
      OP_BEQ       = 8'hF0,
      OP_JMP_ABS   = 8'h4C
   } opcode_e;

   typedef enum logic [4:0] {
      RESET, LDA, LDX, LDY,
      LDA_ZP, LDA_ABS, LDA_ABS_X, LDA_ABS_Y, LDA_ADDR,
      STA_ZP, STA_ABS, STA_ABS_X, STA_ADDR, STA,
      INX, INY, CMP, CPX, CPY,
      JMP, BRANCH, NO_BRANCH, NOP
   } micro_op_e;

   // The low byte doubles as immediate, zero-page address and branch offset.
   typedef union packed {
      addr_t abs;
      struct packed {
         data_t hi;
         data_t lo;
      } bytes;
   } operand_u;

   typedef struct packed {
      logic  rd;
      logic  word;
      logic  wr;
      addr_t addr;
      data_t wr_data;
   } bus_req_s;

   typedef struct packed {
      logic     ack;
      operand_u operand;
   } bus_rsp_s;

   typedef struct packed {
      logic                         valid;
      micro_op_e                    op;
      logic [`CORNET_PC_STEP_W-1:0] step;
   } exec_cmd_s;

   typedef struct packed {
      logic      valid;
      micro_op_e op;
      addr_t     addr;
   } follow_s;

endpackage

/* logic/fetch_sequencer.sv */
// Fetch sequencer

`timescale 1ns/100ps

module fetch_sequencer (
   input  logic                clk,
   input  logic                reset_n,
   output cornet_pkg::addr_t   fetch_addr,
   output logic                fetch_req,
   input  logic                fetch_rsp,
   input  cornet_pkg::data_t   fetch_data,
   input  logic                inst_done,
   input  cornet_pkg::addr_t   pc_next,
   output cornet_pkg::addr_t   pc,
   output logic                reset_start,
   output logic                exec_start,
   output cornet_pkg::opcode_e opcode
);

   typedef enum logic [2:0] {RESET, FETCH, LOAD, EXECUTE, WAIT} state_e;

   state_e state;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state <= RESET;
      end
      else
      begin
         case (state)
            RESET:
               state <= WAIT;
            FETCH:
               state <= LOAD;
            LOAD:
               if (fetch_rsp)
                  state <= EXECUTE;
            EXECUTE:
               state <= WAIT;
            WAIT:
               if (inst_done)
                  state <= FETCH;
            default:
               state <= RESET;
         endcase
      end
   end

   // PC only ever comes from the execute unit, the first time from the vector.
   always_ff @(posedge clk)
   begin
      if (state == WAIT && inst_done)
         pc <= pc_next;
      if (state == LOAD && fetch_rsp)
         opcode <= cornet_pkg::opcode_e'(fetch_data);
   end

   assign fetch_addr  = pc;
   assign fetch_req   = (state == FETCH);
   assign reset_start = (state == RESET);
   assign exec_start  = (state == EXECUTE);

endmodule

/* logic/inst_decoder.sv */
// Instruction decoder

`timescale 1ns/100ps
`include "cornet_defines.svh"

module inst_decoder (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  reset_start,
   input  logic                  exec_start,
   input  cornet_pkg::opcode_e   opcode,
   input  cornet_pkg::addr_t     pc,
   input  logic                  flag_z,
   input  cornet_pkg::follow_s   follow,
   output cornet_pkg::bus_req_s  bus_req,
   output cornet_pkg::exec_cmd_s exec_cmd,
   input  cornet_pkg::data_t     acc
);

   cornet_pkg::micro_op_e        dec_op;
   logic                         dec_rd;
   logic                         dec_word;
   logic [`CORNET_PC_STEP_W-1:0] dec_step;

   always_comb
   begin
      dec_op = cornet_pkg::NOP;
      case (opcode)
         cornet_pkg::OP_LDY_IMM:   dec_op = cornet_pkg::LDY;
         cornet_pkg::OP_LDX_IMM:   dec_op = cornet_pkg::LDX;
         cornet_pkg::OP_LDA_IMM:   dec_op = cornet_pkg::LDA;
         cornet_pkg::OP_LDA_ZP:    dec_op = cornet_pkg::LDA_ZP;
         cornet_pkg::OP_LDA_ABS:   dec_op = cornet_pkg::LDA_ABS;
         cornet_pkg::OP_LDA_ABS_X: dec_op = cornet_pkg::LDA_ABS_X;
         cornet_pkg::OP_LDA_ABS_Y: dec_op = cornet_pkg::LDA_ABS_Y;
         cornet_pkg::OP_STA_ZP:    dec_op = cornet_pkg::STA_ZP;
         cornet_pkg::OP_STA_ABS:   dec_op = cornet_pkg::STA_ABS;
         cornet_pkg::OP_STA_ABS_X: dec_op = cornet_pkg::STA_ABS_X;
         cornet_pkg::OP_INX:       dec_op = cornet_pkg::INX;
         cornet_pkg::OP_INY:       dec_op = cornet_pkg::INY;
         cornet_pkg::OP_CMP_IMM:   dec_op = cornet_pkg::CMP;
         cornet_pkg::OP_CPX_IMM:   dec_op = cornet_pkg::CPX;
         cornet_pkg::OP_CPY_IMM:   dec_op = cornet_pkg::CPY;
         cornet_pkg::OP_BNE:
            dec_op = flag_z ? cornet_pkg::NO_BRANCH : cornet_pkg::BRANCH;
         cornet_pkg::OP_BEQ:
            dec_op = flag_z ? cornet_pkg::BRANCH : cornet_pkg::NO_BRANCH;
         cornet_pkg::OP_JMP_ABS:   dec_op = cornet_pkg::JMP;
         default:                  dec_op = cornet_pkg::NOP;
      endcase
   end

   // operand size follows from the micro-op.
   always_comb
   begin
      dec_rd   = 1'b1;
      dec_word = 1'b0;
      dec_step = 2'd2;
      case (dec_op)
         cornet_pkg::INX, cornet_pkg::INY, cornet_pkg::NOP:
         begin
            dec_rd   = 1'b0;
            dec_step = 2'd1;
         end
         cornet_pkg::NO_BRANCH:
            dec_rd = 1'b0;
         cornet_pkg::LDA_ABS, cornet_pkg::LDA_ABS_X, cornet_pkg::LDA_ABS_Y,
         cornet_pkg::STA_ABS, cornet_pkg::STA_ABS_X, cornet_pkg::JMP:
         begin
            dec_word = 1'b1;
            dec_step = 2'd3;
         end
         default:
            dec_step = 2'd2;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         bus_req.rd     <= 1'b0;
         bus_req.wr     <= 1'b0;
         exec_cmd.valid <= 1'b0;
      end
      else
      begin
         bus_req.rd     <= 1'b0;
         bus_req.wr     <= 1'b0;
         exec_cmd.valid <= 1'b0;
         if (reset_start)
         begin
            bus_req.rd   <= 1'b1;
            bus_req.word <= 1'b1;
            bus_req.addr <= `CORNET_RESET_VECTOR;
            exec_cmd     <= '{1'b1, cornet_pkg::RESET, '0};
         end
         else if (exec_start)
         begin
            bus_req.rd   <= dec_rd;
            bus_req.word <= dec_word;
            bus_req.addr <= pc + 1'b1;
            exec_cmd     <= '{1'b1, dec_op, dec_step};
         end
         else if (follow.valid)
         begin
            // The step of the first command stays in place for the second access.
            bus_req.addr   <= follow.addr;
            exec_cmd.valid <= 1'b1;
            if (follow.op == cornet_pkg::STA_ADDR)
            begin
               bus_req.wr      <= 1'b1;
               bus_req.wr_data <= acc;
               exec_cmd.op     <= cornet_pkg::STA;
            end
            else
            begin
               bus_req.rd   <= 1'b1;
               bus_req.word <= 1'b0;
               exec_cmd.op  <= cornet_pkg::LDA;
            end
         end
      end
   end

endmodule

/* logic/bus_unit.sv */
// Memory bus unit

`timescale 1ns/100ps

module bus_unit (
   input  logic                 clk,
   input  logic                 reset_n,
   input  cornet_pkg::addr_t    fetch_addr,
   input  logic                 fetch_req,
   output logic                 fetch_rsp,
   output cornet_pkg::data_t    fetch_data,
   input  cornet_pkg::bus_req_s bus_req,
   output cornet_pkg::bus_rsp_s bus_rsp,
   output cornet_pkg::addr_t    addr,
   output logic                 rd_req,
   input  cornet_pkg::data_t    rd_data,
   input  logic                 ready,
   output logic                 wr_en,
   output cornet_pkg::data_t    wr_data
);

   typedef enum logic [2:0] {IDLE, FETCH, BYTE, WORD_L, WORD_H} state_e;

   state_e state;
   logic   rd_done;

   // ready only counts once the request pulse is gone.
   assign rd_done = ready && !rd_req;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state       <= IDLE;
         rd_req      <= 1'b0;
         wr_en       <= 1'b0;
         fetch_rsp   <= 1'b0;
         bus_rsp.ack <= 1'b0;
      end
      else
      begin
         rd_req      <= 1'b0;
         wr_en       <= 1'b0;
         fetch_rsp   <= 1'b0;
         bus_rsp.ack <= 1'b0;
         case (state)
            IDLE:
            begin
               if (fetch_req)
               begin
                  addr   <= fetch_addr;
                  rd_req <= 1'b1;
                  state  <= FETCH;
               end
               else if (bus_req.rd)
               begin
                  addr   <= bus_req.addr;
                  rd_req <= 1'b1;
                  state  <= bus_req.word ? WORD_L : BYTE;
               end
               else if (bus_req.wr)
               begin
                  addr    <= bus_req.addr;
                  wr_data <= bus_req.wr_data;
                  wr_en   <= 1'b1;
               end
            end
            FETCH:
               if (rd_done)
               begin
                  fetch_data <= rd_data;
                  fetch_rsp  <= 1'b1;
                  state      <= IDLE;
               end
            BYTE:
               if (rd_done)
               begin
                  bus_rsp.operand.bytes.hi <= '0;
                  bus_rsp.operand.bytes.lo <= rd_data;
                  bus_rsp.ack              <= 1'b1;
                  state                    <= IDLE;
               end
            WORD_L:
               if (rd_done)
               begin
                  bus_rsp.operand.bytes.lo <= rd_data;
                  addr                     <= addr + 1'b1;
                  rd_req                   <= 1'b1;
                  state                    <= WORD_H;
               end
            WORD_H:
               if (rd_done)
               begin
                  bus_rsp.operand.bytes.hi <= rd_data;
                  bus_rsp.ack              <= 1'b1;
                  state                    <= IDLE;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

/* logic/exec_unit.sv */
// Execute unit

`timescale 1ns/100ps

module exec_unit (
   input  logic                  clk,
   input  logic                  reset_n,
   input  cornet_pkg::exec_cmd_s exec_cmd,
   input  cornet_pkg::bus_rsp_s  bus_rsp,
   input  cornet_pkg::addr_t     pc,
   output cornet_pkg::follow_s   follow,
   output cornet_pkg::data_t     acc,
   output logic                  flag_z,
   output logic                  inst_done,
   output cornet_pkg::addr_t     pc_next
);

   cornet_pkg::data_t reg_x;
   cornet_pkg::data_t reg_y;
   cornet_pkg::data_t operand_byte;
   cornet_pkg::data_t index;
   cornet_pkg::addr_t pc_step;
   cornet_pkg::addr_t base_addr;
   cornet_pkg::addr_t eff_addr;
   logic              is_store;

   // The decoder holds the command fields until its next command.
   assign operand_byte = bus_rsp.operand.bytes.lo;
   assign pc_step      = pc + cornet_pkg::addr_t'(exec_cmd.step);

   always_comb
   begin
      base_addr = bus_rsp.operand.abs;
      index     = '0;
      is_store  = 1'b0;
      case (exec_cmd.op)
         cornet_pkg::LDA_ZP:
            base_addr = cornet_pkg::addr_t'(operand_byte);
         cornet_pkg::LDA_ABS_X:
            index = reg_x;
         cornet_pkg::LDA_ABS_Y:
            index = reg_y;
         cornet_pkg::STA_ZP:
         begin
            base_addr = cornet_pkg::addr_t'(operand_byte);
            is_store  = 1'b1;
         end
         cornet_pkg::STA_ABS:
            is_store = 1'b1;
         cornet_pkg::STA_ABS_X:
         begin
            index    = reg_x;
            is_store = 1'b1;
         end
         default:
            index = '0;
      endcase
   end

   // the index is added in 16 bits so that it carries into the high byte.
   assign eff_addr = base_addr + cornet_pkg::addr_t'(index);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         inst_done    <= 1'b0;
         follow.valid <= 1'b0;
         flag_z       <= 1'b0;
      end
      else
      begin
         inst_done    <= 1'b0;
         follow.valid <= 1'b0;
         pc_next      <= pc_step;
         if (exec_cmd.valid)
         begin
            case (exec_cmd.op)
               cornet_pkg::INX:
               begin
                  reg_x     <= reg_x + 1'b1;
                  flag_z    <= (reg_x == '1);
                  inst_done <= 1'b1;
               end
               cornet_pkg::INY:
               begin
                  reg_y     <= reg_y + 1'b1;
                  flag_z    <= (reg_y == '1);
                  inst_done <= 1'b1;
               end
               cornet_pkg::STA, cornet_pkg::NO_BRANCH, cornet_pkg::NOP:
                  inst_done <= 1'b1;
               default:
                  inst_done <= 1'b0;
            endcase
         end
         if (bus_rsp.ack)
         begin
            case (exec_cmd.op)
               cornet_pkg::RESET:
               begin
                  acc       <= '0;
                  reg_x     <= '0;
                  pc_next   <= bus_rsp.operand.abs;
                  inst_done <= 1'b1;
               end
               cornet_pkg::LDA:
               begin
                  acc       <= operand_byte;
                  flag_z    <= (operand_byte == '0);
                  inst_done <= 1'b1;
               end
               cornet_pkg::LDX:
               begin
                  reg_x     <= operand_byte;
                  inst_done <= 1'b1;
               end
               cornet_pkg::LDY:
               begin
                  reg_y     <= operand_byte;
                  inst_done <= 1'b1;
               end
               cornet_pkg::CMP:
               begin
                  flag_z    <= (acc == operand_byte);
                  inst_done <= 1'b1;
               end
               cornet_pkg::CPX:
               begin
                  flag_z    <= (reg_x == operand_byte);
                  inst_done <= 1'b1;
               end
               cornet_pkg::CPY:
               begin
                  flag_z    <= (reg_y == operand_byte);
                  inst_done <= 1'b1;
               end
               cornet_pkg::JMP:
               begin
                  pc_next   <= bus_rsp.operand.abs;
                  inst_done <= 1'b1;
               end
               cornet_pkg::BRANCH:
               begin
                  pc_next   <= pc_step + cornet_pkg::addr_t'($signed(operand_byte));
                  inst_done <= 1'b1;
               end
               cornet_pkg::LDA_ZP, cornet_pkg::LDA_ABS, cornet_pkg::LDA_ABS_X,
               cornet_pkg::LDA_ABS_Y, cornet_pkg::STA_ZP, cornet_pkg::STA_ABS,
               cornet_pkg::STA_ABS_X:
               begin
                  follow.valid <= 1'b1;
                  follow.op    <= is_store ? cornet_pkg::STA_ADDR : cornet_pkg::LDA_ADDR;
                  follow.addr  <= eff_addr;
               end
               default:
                  inst_done <= 1'b0;
            endcase
         end
      end
   end

endmodule

/* logic/cornet_cpu.sv */
// Cornet test CPU

`timescale 1ns/100ps

module cornet_cpu (
   input  logic              clk,
   input  logic              reset_n,
   output cornet_pkg::addr_t addr,
   input  cornet_pkg::data_t rd_data,
   output cornet_pkg::data_t wr_data,
   output logic              wr_en,
   output logic              rd_req,
   input  logic              ready
);

   cornet_pkg::addr_t     fetch_addr;
   logic                  fetch_req;
   logic                  fetch_rsp;
   cornet_pkg::data_t     fetch_data;
   logic                  inst_done;
   cornet_pkg::addr_t     pc_next;
   cornet_pkg::addr_t     pc;
   logic                  reset_start;
   logic                  exec_start;
   cornet_pkg::opcode_e   opcode;
   logic                  flag_z;
   cornet_pkg::follow_s   follow;
   cornet_pkg::bus_req_s  bus_req;
   cornet_pkg::bus_rsp_s  bus_rsp;
   cornet_pkg::exec_cmd_s exec_cmd;
   cornet_pkg::data_t     acc;

   fetch_sequencer u_fetch_sequencer (
      .clk         (clk),
      .reset_n     (reset_n),
      .fetch_addr  (fetch_addr),
      .fetch_req   (fetch_req),
      .fetch_rsp   (fetch_rsp),
      .fetch_data  (fetch_data),
      .inst_done   (inst_done),
      .pc_next     (pc_next),
      .pc          (pc),
      .reset_start (reset_start),
      .exec_start  (exec_start),
      .opcode      (opcode)
   );

   inst_decoder u_inst_decoder (
      .clk         (clk),
      .reset_n     (reset_n),
      .reset_start (reset_start),
      .exec_start  (exec_start),
      .opcode      (opcode),
      .pc          (pc),
      .flag_z      (flag_z),
      .follow      (follow),
      .bus_req     (bus_req),
      .exec_cmd    (exec_cmd),
      .acc         (acc)
   );

   bus_unit u_bus_unit (
      .clk        (clk),
      .reset_n    (reset_n),
      .fetch_addr (fetch_addr),
      .fetch_req  (fetch_req),
      .fetch_rsp  (fetch_rsp),
      .fetch_data (fetch_data),
      .bus_req    (bus_req),
      .bus_rsp    (bus_rsp),
      .addr       (addr),
      .rd_req     (rd_req),
      .rd_data    (rd_data),
      .ready      (ready),
      .wr_en      (wr_en),
      .wr_data    (wr_data)
   );

   exec_unit u_exec_unit (
      .clk       (clk),
      .reset_n   (reset_n),
      .exec_cmd  (exec_cmd),
      .bus_rsp   (bus_rsp),
      .pc        (pc),
      .follow    (follow),
      .acc       (acc),
      .flag_z    (flag_z),
      .inst_done (inst_done),
      .pc_next   (pc_next)
   );

endmodule

/* test/cornet_cpu_chk.sv */
// Memory port protocol checks

`timescale 1ns/100ps

module cornet_cpu_chk (
   input logic clk,
   input logic reset_n,
   input logic rd_req,
   input logic wr_en,
   input logic ready
);

   // set from a read request until its ready.
   logic outstanding;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         outstanding <= 1'b0;
      else if (rd_req)
         outstanding <= 1'b1;
      else if (ready)
         outstanding <= 1'b0;
   end

   no_read_write_overlap: assert property (
      @(posedge clk) disable iff (!reset_n) !(rd_req && wr_en))
      else $error("rd_req and wr_en are high together");

   quiet_in_reset: assert property (
      @(posedge clk) !reset_n |=> (!rd_req && !wr_en))
      else $error("memory port is active during reset");

   one_read_at_a_time: assert property (
      @(posedge clk) disable iff (!reset_n) outstanding |-> !rd_req)
      else $error("rd_req issued before the previous read got its ready");

endmodule

bind cornet_cpu cornet_cpu_chk u_cornet_cpu_chk (
   .clk     (clk),
   .reset_n (reset_n),
   .rd_req  (rd_req),
   .wr_en   (wr_en),
   .ready   (ready)
);

/* test/tb_cornet_cpu.sv */
// Cornet CPU testbench

`timescale 1ns/100ps
`include "cornet_defines.svh"

module tb_cornet_cpu;

   // two passes of about 40 instructions each, under 25 cycles apiece with slow memory.
   localparam int max_cycles = 4000;

   typedef struct packed {
      cornet_pkg::addr_t addr;
      cornet_pkg::data_t data;
   } write_s;

   logic              clk = 1'b0;
   logic              reset_n;
   cornet_pkg::addr_t addr;
   cornet_pkg::data_t rd_data = '0;
   cornet_pkg::data_t wr_data;
   logic              wr_en;
   logic              rd_req;
   logic              ready = 1'b0;

   cornet_pkg::data_t mem [0:65535];
   write_s            exp_writes [$];
   cornet_pkg::addr_t exp_reads [$];
   cornet_pkg::addr_t load_ptr;
   cornet_pkg::addr_t end_addr;
   cornet_pkg::addr_t pend_addr;
   logic [31:0]       lfsr = 32'hd3c3_f85f;
   logic              slow_mem;
   logic              read_pending = 1'b0;
   int                wait_left;
   int                end_count = 0;
   int                cycle_count;
   int                write_errors = 0;
   int                read_errors = 0;
   int                other_errors = 0;

   cornet_cpu u_cornet_cpu (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b    = lfsr[0];
   endtask

   task automatic draw_latency(output int lat);
      logic b0;
      logic b1;
      lat = 1;
      if (slow_mem)
      begin
         take_bit(b0);
         take_bit(b1);
         lat = 1 + int'({b1, b0});
      end
   endtask

   task automatic check_write(input cornet_pkg::addr_t got_addr,
                              input cornet_pkg::data_t got_data);
      write_s want;
      if (exp_writes.size() == 0)
      begin
         $display("%0t: write of %h to %h that the program does not make",
                  $time, got_data, got_addr);
         write_errors++;
      end
      else
      begin
         want = exp_writes.pop_front();
         if (got_addr !== want.addr || got_data !== want.data)
         begin
            $display("CHECK FAILED at %0t: write %h to %h, expected %h to %h",
                     $time, got_data, got_addr, want.data, want.addr);
            write_errors++;
         end
      end
   endtask

   task automatic check_read_addr(input cornet_pkg::addr_t got);
      cornet_pkg::addr_t want;
      want = exp_reads.pop_front();
      if (got !== want)
      begin
         $display("CHECK FAILED at %0t: read at %h, expected %h", $time, got, want);
         read_errors++;
      end
   endtask

   // The memory model answers each read after a drawn number of cycles.
   always @(posedge clk)
   begin
      logic              seen_rd;
      logic              seen_wr;
      logic              seen_rst;
      cornet_pkg::addr_t seen_addr;
      cornet_pkg::data_t seen_data;
      int                lat;
      seen_rd   = rd_req;
      seen_wr   = wr_en;
      seen_rst  = reset_n;
      seen_addr = addr;
      seen_data = wr_data;
      #1;
      ready = 1'b0;
      if (!seen_rst)
         read_pending = 1'b0;
      else
      begin
         if (seen_wr)
            check_write(seen_addr, seen_data);
         if (seen_rd)
         begin
            if (exp_reads.size() > 0)
               check_read_addr(seen_addr);
            if (seen_addr == end_addr)
               end_count++;
            draw_latency(lat);
            pend_addr    = seen_addr;
            wait_left    = lat;
            read_pending = 1'b1;
         end
         if (read_pending)
         begin
            wait_left--;
            if (wait_left == 0)
            begin
               ready        = 1'b1;
               rd_data      = mem[pend_addr];
               read_pending = 1'b0;
            end
         end
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < max_cycles)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: a program did not reach its end within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

   task automatic hold_reset();
      @(posedge clk);
      #1;
      reset_n = 1'b0;
      @(posedge clk);
      exp_writes.delete();
      exp_reads.delete();
   endtask

   // fill depends on every address bit so that a wrong address reads a wrong byte.
   task automatic clear_memory();
      for (int i = 0; i < 65536; i++)
         mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'ha5;
   endtask

   task automatic set_origin(input cornet_pkg::addr_t a);
      load_ptr                         = a;
      mem[`CORNET_RESET_VECTOR]        = a[7:0];
      mem[`CORNET_RESET_VECTOR + 16'd1] = a[15:8];
   endtask

   task automatic emit_op(input cornet_pkg::data_t opc);
      mem[load_ptr] = opc;
      load_ptr      = load_ptr + 16'd1;
   endtask

   task automatic emit_imm(input cornet_pkg::data_t opc, input cornet_pkg::data_t b);
      emit_op(opc);
      emit_op(b);
   endtask

   task automatic emit_abs(input cornet_pkg::data_t opc, input cornet_pkg::addr_t a);
      emit_op(opc);
      emit_op(a[7:0]);
      emit_op(a[15:8]);
   endtask

   task automatic expect_write(input cornet_pkg::addr_t a, input cornet_pkg::data_t d);
      exp_writes.push_back(write_s'{addr: a, data: d});
   endtask

   task automatic run_to_end(input cornet_pkg::addr_t end_a, input string name);
      int start_count;
      start_count = end_count;
      end_addr    = end_a;
      repeat (2) @(posedge clk);
      #1;
      reset_n = 1'b1;
      while (end_count == start_count)
         @(posedge clk);
      if (exp_writes.size() != 0 || exp_reads.size() != 0)
      begin
         $display("%0t: %s ended with %0d writes and %0d reads still missing",
                  $time, name, exp_writes.size(), exp_reads.size());
         other_errors++;
      end
      $display("%0t: %s finished", $time, name);
   endtask

   task automatic test_reset();
      hold_reset();
      clear_memory();
      set_origin(16'h0200);
      emit_abs(8'h4c, 16'h0200);
      exp_reads.push_back(`CORNET_RESET_VECTOR);
      exp_reads.push_back(`CORNET_RESET_VECTOR + 16'd1);
      exp_reads.push_back(16'h0200);
      run_to_end(16'h0200, "reset vector");
   endtask

   task automatic test_load_store();
      hold_reset();
      clear_memory();
      set_origin(16'h0280);
      emit_imm(8'ha9, 8'h5a);
      emit_imm(8'h85, 8'h10);
      emit_abs(8'h8d, 16'h0345);
      emit_abs(8'h4c, 16'h0287);
      expect_write(16'h0010, 8'h5a);
      expect_write(16'h0345, 8'h5a);
      run_to_end(16'h0287, "load and store");
   endtask

   task automatic test_indexed();
      hold_reset();
      clear_memory();
      // the byte without the carry into the high address byte differs.
      mem[16'h0508] = 8'hc3;
      mem[16'h0408] = 8'h3c;
      set_origin(16'h0700);
      emit_imm(8'ha2, 8'h05);
      emit_imm(8'ha9, 8'h77);
      emit_abs(8'h9d, 16'h0300);
      emit_imm(8'ha0, 8'h10);
      emit_abs(8'hbe, 16'h04f8);
      emit_imm(8'h85, 8'h20);
      emit_abs(8'h4c, 16'h070e);
      expect_write(16'h0300 + 16'h0005, 8'h77);
      expect_write(16'h0020, 8'hc3);
      run_to_end(16'h070e, "indexed addressing");
   endtask

   task automatic test_branch_loop();
      hold_reset();
      clear_memory();
      set_origin(16'h0600);
      emit_imm(8'ha2, 8'h00);
      emit_imm(8'ha9, 8'hab);
      emit_op(8'he8);
      emit_abs(8'h9d, 16'h0400);
      emit_imm(8'he0, 8'h04);
      emit_imm(8'hd0, 8'hf8);
      emit_imm(8'he0, 8'h00);
      emit_imm(8'hf0, 8'h02);
      emit_imm(8'h85, 8'h21);
      emit_abs(8'h4c, 16'h0617);
      emit_imm(8'h85, 8'h22);
      emit_imm(8'h85, 8'h23);
      emit_abs(8'h4c, 16'h0619);
      for (int n = 1; n <= 4; n++)
         expect_write(16'h0400 + n[15:0], 8'hab);
      expect_write(16'h0021, 8'hab);
      expect_write(16'h0023, 8'hab);
      run_to_end(16'h0619, "compare and branch");
   endtask

   initial
   begin
      reset_n  = 1'b0;
      slow_mem = 1'b0;
      test_reset();
      test_load_store();
      test_indexed();
      test_branch_loop();
      // same programs again with ready held back for 1 to 4 cycles.
      slow_mem = 1'b1;
      test_reset();
      test_load_store();
      test_indexed();
      test_branch_loop();
      $display("errors: %0d write, %0d read address, %0d other",
               write_errors, read_errors, other_errors);
      if (write_errors + read_errors + other_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* files.f */
+incdir+common
common/cornet_pkg.sv
logic/fetch_sequencer.sv
logic/inst_decoder.sv
logic/bus_unit.sv
logic/exec_unit.sv
logic/cornet_cpu.sv
test/cornet_cpu_chk.sv
test/tb_cornet_cpu.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cornet_cpu
FILELIST = files.f
MDIR     = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)

run: build
	./$(MDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run stopped early"; exit 1; fi

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR) $(LOG)
